// File: logic/vic_config.svh
`ifndef VIC_CONFIG_SVH
`define VIC_CONFIG_SVH

// --------------------
// chip variants
// --------------------
// code 3 falls through to the 6569 limits
`define VIC_CHIP_6567R8      2'd0
`define VIC_CHIP_6567R56A    2'd1
`define VIC_CHIP_6569        2'd2

// last raster_x and last raster_line per chip
// 520 pixels, 263 lines
`define VIC_XMAX_6567R8      10'd519
`define VIC_YMAX_6567R8      9'd262
// 512 pixels, 262 lines
`define VIC_XMAX_6567R56A    10'd511
`define VIC_YMAX_6567R56A    9'd261
// 504 pixels, 312 lines
`define VIC_XMAX_6569        10'd503
`define VIC_YMAX_6569        9'd311

// --------------------
// phase ticks
// --------------------
// dot4x ticks in one phi half
`define VIC_PHASE_TICKS      16
// cpu bus sampled here in the phi high phase
`define VIC_DATA_DAV         14
// raster compare fires here in the phi low phase
`define VIC_IRQ_TICK         8

// badline window, lines and cycles
`define VIC_BADLINE_FIRST    9'd48
`define VIC_BADLINE_LAST     9'd247
`define VIC_BA_CYCLE_FIRST   7'd12
`define VIC_BA_CYCLE_LAST    7'd54

// register addresses
`define VIC_REG_CTRL1        6'h11
`define VIC_REG_RASTER       6'h12
`define VIC_REG_IRQ          6'h19
`define VIC_REG_IRQ_EN       6'h1a

`endif

// File: logic/vic_pkg.sv
`include "vic_config.svh"

package vic_pkg;

    // --------------------
    // scalar widths
    // --------------------
    // chip variant select
    typedef logic [1:0] chip_t;
    // pixel within a line
    typedef logic [9:0] raster_x_t;
    // line within a frame
    typedef logic [8:0] raster_line_t;
    // 8-pixel cycle, raster_x / 8
    typedef logic [6:0] cycle_num_t;
    // cpu register port
    typedef logic [5:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // --------------------
    // bundles
    // --------------------
    // phi clock and tick strobes
    typedef struct packed {
        logic                        clk_phi;
        // one-hot, bit k is tick k of the current phi half
        logic [`VIC_PHASE_TICKS-1:0] phase_start;
        // last dot4x tick of each pixel
        logic                        dot_tick;
    } phase_s;

    // beam position
    typedef struct packed {
        raster_x_t    raster_x;
        raster_line_t raster_line;
        cycle_num_t   cycle_num;
    } raster_pos_s;

    // control bits from $d011/$d012
    typedef struct packed {
        logic         den;
        logic [2:0]   yscroll;
        // raster compare value
        raster_line_t irq_line;
    } vic_ctrl_s;

endpackage

// File: logic/phase_gen.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module phase_gen (
    input  logic            clk_dot4x,
    input  logic            rst,
    output vic_pkg::phase_s phase_o
);

    // one full phi period, bit 0 is the phi level
    logic [2*`VIC_PHASE_TICKS-1:0] phi_gen;
    // tick position inside the current phi half
    logic [`VIC_PHASE_TICKS-1:0] phase_start;
    // tick position inside a pixel, runs 1 2 3 0
    // bit 0 is the last tick of the pixel
    logic [3:0] dot_rising;

    // reset leaves phi low, a quarter into its phase,
    // so the beam at (0,0) lines up with the first pixel
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_gen     <= 32'b0000_0000_0000_1111_1111_1111_1111_0000;
            phase_start <= 16'b0000_0000_0000_1000;
            dot_rising  <= 4'b1000;
        end else begin
            // all three rotate left
            phi_gen     <= {phi_gen[2*`VIC_PHASE_TICKS-2:0],
                            phi_gen[2*`VIC_PHASE_TICKS-1]};
            phase_start <= {phase_start[`VIC_PHASE_TICKS-2:0],
                            phase_start[`VIC_PHASE_TICKS-1]};
            dot_rising  <= {dot_rising[2:0], dot_rising[3]};
        end
    end

    assign phase_o.clk_phi     = phi_gen[0];
    assign phase_o.phase_start = phase_start;
    assign phase_o.dot_tick    = dot_rising[0];

    // every tick decoder downstream relies on a single active bit
    assert property (@(posedge clk_dot4x) disable iff (rst)
        $onehot(phase_start));

    // tick 0 of a half must be the first tick after a phi edge
    assert property (@(posedge clk_dot4x) disable iff (rst)
        phase_start[0] |-> (phi_gen[0] != $past(phi_gen[0])));

endmodule

// File: logic/raster_counter.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module raster_counter (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  vic_pkg::chip_t        chip_i,
    input  vic_pkg::phase_s       phase_i,
    input  vic_pkg::raster_line_t irq_line_i,
    output vic_pkg::raster_pos_s  pos_o,
    output logic                  raster_hit_o
);

    import vic_pkg::*;

    // selected limits
    raster_x_t    x_max;
    raster_line_t y_max;

    // beam position
    raster_x_t    raster_x;
    raster_line_t raster_line;

    // compare already fired on this line
    logic irq_triggered;
    logic raster_hit;

    // --------------------
    // per-chip limits
    // --------------------
    always_comb begin
        case (chip_i)
            `VIC_CHIP_6567R8: begin
                x_max = `VIC_XMAX_6567R8;
                y_max = `VIC_YMAX_6567R8;
            end
            `VIC_CHIP_6567R56A: begin
                x_max = `VIC_XMAX_6567R56A;
                y_max = `VIC_YMAX_6567R56A;
            end
            // 6569 and the spare code
            default: begin
                x_max = `VIC_XMAX_6569;
                y_max = `VIC_YMAX_6569;
            end
        endcase
    end

    // --------------------
    // beam counters
    // --------------------
    // one pixel per dot_tick, line advances on the x wrap
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x    <= '0;
            raster_line <= '0;
        end else if (phase_i.dot_tick) begin
            if (raster_x >= x_max) begin
                raster_x <= '0;
                if (raster_line >= y_max) begin
                    raster_line <= '0;
                end else begin
                    raster_line <= raster_line + 1'b1;
                end
            end else begin
                raster_x <= raster_x + 1'b1;
            end
        end
    end

    // --------------------
    // raster compare
    // --------------------
    // live line against the compare value, at most one hit per line
    // the flag rearms once the line no longer matches
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irq_triggered <= 1'b0;
            raster_hit    <= 1'b0;
        end else begin
            raster_hit <= 1'b0;
            if (raster_line == irq_line_i) begin
                if (!phase_i.clk_phi && phase_i.phase_start[`VIC_IRQ_TICK] &&
                        !irq_triggered) begin
                    irq_triggered <= 1'b1;
                    raster_hit    <= 1'b1;
                end
            end else begin
                irq_triggered <= 1'b0;
            end
        end
    end

    assign pos_o.raster_x    = raster_x;
    assign pos_o.raster_line = raster_line;
    // 8 pixels per cycle
    assign pos_o.cycle_num   = raster_x[9:3];
    assign raster_hit_o      = raster_hit;

    // beam stays inside the line of the selected chip
    assert property (@(posedge clk_dot4x) disable iff (rst)
        raster_x <= x_max);

endmodule

// File: logic/vic_registers.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module vic_registers (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  vic_pkg::phase_s       phase_i,
    input  logic                  ce_i,
    input  logic                  rw_i,
    input  vic_pkg::reg_addr_t    adi_i,
    input  vic_pkg::reg_data_t    dbi_i,
    input  vic_pkg::raster_line_t raster_line_i,
    input  logic                  raster_hit_i,
    output vic_pkg::vic_ctrl_s    ctrl_o,
    output vic_pkg::reg_data_t    dbo_o,
    output logic                  irq_o
);

    import vic_pkg::*;

    // $d011/$d012 write fields
    vic_ctrl_s ctrl_q;
    // raster interrupt latch and enable
    logic      irst;
    logic      erst;

    // bus strobes
    logic      bus_tick;
    logic      wr_en;
    logic      rd_en;
    logic      irst_clr;

    // read path
    reg_data_t rd_data;
    reg_data_t dbo_q;

    // --------------------
    // bus decode
    // --------------------
    // chip selected and sampled once per phi high phase
    assign bus_tick = phase_i.clk_phi && phase_i.phase_start[`VIC_DATA_DAV] && !ce_i;
    assign wr_en    = bus_tick && !rw_i;
    assign rd_en    = bus_tick && rw_i;
    // writing 1 to bit 0 of $d019 acks the raster irq
    assign irst_clr = wr_en && (adi_i == `VIC_REG_IRQ) && dbi_i[0];

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl_q <= '0;
            erst   <= 1'b0;
        end else if (wr_en) begin
            case (adi_i)
                `VIC_REG_CTRL1: begin
                    // bit 7 is compare bit 8
                    ctrl_q.irq_line[8] <= dbi_i[7];
                    ctrl_q.den         <= dbi_i[4];
                    ctrl_q.yscroll     <= dbi_i[2:0];
                end
                `VIC_REG_RASTER: ctrl_q.irq_line[7:0] <= dbi_i;
                `VIC_REG_IRQ_EN: erst <= dbi_i[0];
                default: ;
            endcase
        end
    end

    // latch sets on a compare hit and an ack wins if both land together
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst <= 1'b0;
        end else begin
            if (raster_hit_i) begin
                irst <= 1'b1;
            end
            if (irst_clr) begin
                irst <= 1'b0;
            end
        end
    end

    // --------------------
    // read side
    // --------------------
    always_comb begin
        case (adi_i)
            // live raster bit 8 and unused bits read 0
            `VIC_REG_CTRL1: rd_data = {raster_line_i[8], 2'b00, ctrl_q.den, 1'b0,
                                       ctrl_q.yscroll};
            `VIC_REG_RASTER: rd_data = raster_line_i[7:0];
            // unused bits read 1
            `VIC_REG_IRQ:    rd_data = {irq_o, 6'b11_1111, irst};
            `VIC_REG_IRQ_EN: rd_data = {7'b111_1111, erst};
            default:         rd_data = 8'hff;
        endcase
    end

    // read data held until the next read
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dbo_q <= '0;
        end else if (rd_en) begin
            dbo_q <= rd_data;
        end
    end

    assign ctrl_o = ctrl_q;
    assign dbo_o  = dbo_q;
    // latch can be pending while disabled so enabling it raises irq at once
    assign irq_o  = irst & erst;

    // compare hits land in phi low and never meet the bus sample tick of phi high
    assert property (@(posedge clk_dot4x) disable iff (rst)
        raster_hit_i |-> !phase_i.clk_phi);

endmodule

// File: logic/badline_arbiter.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module badline_arbiter (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_pkg::phase_s      phase_i,
    input  vic_pkg::raster_pos_s pos_i,
    input  vic_pkg::vic_ctrl_s   ctrl_i,
    output logic                 ba_o,
    output logic                 aec_o
);

    // tick 1 of phi low, cycle_num and raster_line are settled here
    logic eval_tick;
    logic allow_bad_lines;
    logic allow_next;
    logic badline;

    // char fetch window
    logic ba_chars;
    logic ba;
    // ba history across phi high phases
    logic ba1;
    logic ba2;
    logic ba3;

    // phi level one tick ahead
    logic phi_next;
    logic aec;

    assign eval_tick = !phase_i.clk_phi && phase_i.phase_start[1];

    // --------------------
    // badline condition
    // --------------------
    // den anywhere on line 48 opens the window, line 248 closes it
    always_comb begin
        allow_next = allow_bad_lines;
        if (ctrl_i.den && pos_i.raster_line == `VIC_BADLINE_FIRST) begin
            allow_next = 1'b1;
        end
        if (pos_i.raster_line == `VIC_BADLINE_LAST + 9'd1) begin
            allow_next = 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline         <= 1'b0;
        end else if (eval_tick) begin
            allow_bad_lines <= allow_next;
            // uses the updated allow so line 48 itself can qualify
            badline <= allow_next &&
                       pos_i.raster_line >= `VIC_BADLINE_FIRST &&
                       pos_i.raster_line <= `VIC_BADLINE_LAST &&
                       pos_i.raster_line[2:0] == ctrl_i.yscroll;
        end
    end

    // --------------------
    // ba and aec
    // --------------------
    // low across the c-access cycles, 3 ahead of the first fetch
    assign ba_chars = !(badline &&
                        pos_i.cycle_num >= `VIC_BA_CYCLE_FIRST &&
                        pos_i.cycle_num <= `VIC_BA_CYCLE_LAST);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba <= 1'b1;
        end else begin
            ba <= ba_chars;
        end
    end

    // shift ba in at the last tick of phi high
    // cpu keeps the bus for 3 high phases after ba falls
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba1 <= 1'b1;
            ba2 <= 1'b1;
            ba3 <= 1'b1;
        end else if (phase_i.clk_phi && phase_i.phase_start[`VIC_PHASE_TICKS-1]) begin
            ba1 <= ba;
            ba2 <= ba1 | ba;
            ba3 <= ba2 | ba;
        end
    end

    // phi flips on the tick after the last of a half
    assign phi_next = phase_i.clk_phi ^ phase_i.phase_start[`VIC_PHASE_TICKS-1];

    // registered against next phi so aec edges line up with phi edges
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            aec <= 1'b0;
        end else begin
            aec <= phi_next & (ba | ba3);
        end
    end

    assign ba_o  = ba;
    assign aec_o = aec;

    // vic owns the bus in every phi low phase
    assert property (@(posedge clk_dot4x) disable iff (rst)
        aec_o |-> phase_i.clk_phi);

endmodule

// File: logic/vic_top.sv
`timescale 1ns/1ps

module vic_top (
    input  logic               clk_dot4x,
    input  logic               rst,
    input  vic_pkg::chip_t     chip_i,
    input  logic               ce_i,
    input  logic               rw_i,
    input  vic_pkg::reg_addr_t adi_i,
    input  vic_pkg::reg_data_t dbi_i,
    output vic_pkg::reg_data_t dbo_o,
    output logic               irq_o,
    output logic               ba_o,
    output logic               aec_o,
    output logic               clk_phi_o
);

    import vic_pkg::*;

    // phi and tick strobes to every block
    phase_s      phase;
    // beam position
    raster_pos_s pos;
    // control bits from the register file
    vic_ctrl_s   ctrl;
    // one-tick raster compare pulse
    logic        raster_hit;

    phase_gen u_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    raster_counter u_raster_counter (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .chip_i       (chip_i),
        .phase_i      (phase),
        .irq_line_i   (ctrl.irq_line),
        .pos_o        (pos),
        .raster_hit_o (raster_hit)
    );

    vic_registers u_vic_registers (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .phase_i       (phase),
        .ce_i          (ce_i),
        .rw_i          (rw_i),
        .adi_i         (adi_i),
        .dbi_i         (dbi_i),
        .raster_line_i (pos.raster_line),
        .raster_hit_i  (raster_hit),
        .ctrl_o        (ctrl),
        .dbo_o         (dbo_o),
        .irq_o         (irq_o)
    );

    badline_arbiter u_badline_arbiter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .pos_i     (pos),
        .ctrl_i    (ctrl),
        .ba_o      (ba_o),
        .aec_o     (aec_o)
    );

    assign clk_phi_o = phase.clk_phi;

endmodule

// File: bench/tb_vic_tasks.svh
`ifndef TB_VIC_TASKS_SVH
`define TB_VIC_TASKS_SVH

// --------------------
// register bus
// --------------------
// one access per phi high phase, ce held low until phi falls
task automatic bus_access(input logic rd, input reg_addr_t addr,
                          input reg_data_t wdata, output reg_data_t rdata);
    @(negedge clk_dot4x);
    // finish any high phase already running
    while (clk_phi_o) begin
        @(negedge clk_dot4x);
    end
    while (!clk_phi_o) begin
        @(negedge clk_dot4x);
    end
    // first tick of phi high
    ce_i  = 1'b0;
    rw_i  = rd;
    adi_i = addr;
    dbi_i = wdata;
    while (clk_phi_o) begin
        @(negedge clk_dot4x);
    end
    ce_i  = 1'b1;
    rw_i  = 1'b1;
    // read data was loaded at the sample tick and is held
    rdata = dbo_o;
endtask

task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_data_t ignored;
    bus_access(1'b0, addr, data, ignored);
endtask

task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    bus_access(1'b1, addr, 8'h00, data);
endtask

// --------------------
// compares
// --------------------
task automatic check_data(input string name, input reg_data_t expected,
                          input reg_data_t actual);
    if (actual !== expected) begin
        $display("ERR %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("ERR %s: expected %b, actual %b", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
        abort_run();
    end
endtask

`endif

// File: bench/tb_vic.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module tb_vic;

    import vic_pkg::*;

    // frame lengths in dot4x ticks
    localparam int FRAME_R8   = 520 * 263 * 4;
    localparam int FRAME_R56A = 512 * 262 * 4;
    localparam int FRAME_PAL  = 504 * 312 * 4;
    localparam int PAL_LINES  = 312;
    // one frame per irq run plus the badline frame
    // lead-in of up to 100 lines per irq run and the short register test, rounded up
    localparam int TIMEOUT_CYCLES = FRAME_R8 + FRAME_R56A + 2 * FRAME_PAL +
                                    400 * 520 * 4 + 50_000;

    logic      clk_dot4x;
    logic      rst;
    chip_t     chip_i;
    logic      ce_i;
    logic      rw_i;
    reg_addr_t adi_i;
    reg_data_t dbi_i;
    reg_data_t dbo_o;
    logic      irq_o;
    logic      ba_o;
    logic      aec_o;
    logic      clk_phi_o;

    // checker state
    int         cycle_count;
    int         rise_count;
    int         ticks_since_rise;
    int         high_ticks;
    logic       seen_rise;
    logic       phi_prev;
    // bit 0 is the ba sample at the latest phi rise
    logic [3:0] ba_hist;
    logic       aec_expect;
    int         ba_low_count [PAL_LINES];
    logic       irq_must_stay_low;
    logic       ba_must_stay_high;

    vic_top u_vic_top (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .ce_i      (ce_i),
        .rw_i      (rw_i),
        .adi_i     (adi_i),
        .dbi_i     (dbi_i),
        .dbo_o     (dbo_o),
        .irq_o     (irq_o),
        .ba_o      (ba_o),
        .aec_o     (aec_o),
        .clk_phi_o (clk_phi_o)
    );

    // 8 ns dot4x period
    always #4 clk_dot4x = ~clk_dot4x;

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    `include "tb_vic_tasks.svh"

    // --------------------
    // reference model
    // --------------------
    // phi periods per raster line, 8 pixels each
    function automatic int line_cycles(input chip_t chip);
        int xmax;
        case (chip)
            `VIC_CHIP_6567R8:   xmax = int'(`VIC_XMAX_6567R8);
            `VIC_CHIP_6567R56A: xmax = int'(`VIC_XMAX_6567R56A);
            default:            xmax = int'(`VIC_XMAX_6569);
        endcase
        return (xmax + 1) / 8;
    endfunction

    // 4 ticks per pixel
    function automatic int frame_ticks(input chip_t chip);
        int xmax;
        int ymax;
        case (chip)
            `VIC_CHIP_6567R8: begin
                xmax = int'(`VIC_XMAX_6567R8);
                ymax = int'(`VIC_YMAX_6567R8);
            end
            `VIC_CHIP_6567R56A: begin
                xmax = int'(`VIC_XMAX_6567R56A);
                ymax = int'(`VIC_YMAX_6567R56A);
            end
            default: begin
                xmax = int'(`VIC_XMAX_6569);
                ymax = int'(`VIC_YMAX_6569);
            end
        endcase
        return (xmax + 1) * (ymax + 1) * 4;
    endfunction

    // den taken as set before line 48
    function automatic bit is_badline(input int line, input logic [2:0] yscroll);
        return line >= int'(`VIC_BADLINE_FIRST) && line <= int'(`VIC_BADLINE_LAST) &&
               3'(line % 8) == yscroll;
    endfunction

    // cpu keeps the bus for three more cycles after ba falls
    function automatic logic expected_aec(input logic [3:0] hist);
        return |hist;
    endfunction

    // --------------------
    // sequence helpers
    // --------------------
    // 3 cycles of reset, chip changes only while reset is held
    task automatic apply_reset(input chip_t chip);
        @(posedge clk_dot4x);
        irq_must_stay_low = 1'b0;
        ba_must_stay_high = 1'b0;
        @(negedge clk_dot4x);
        rst = 1'b1;
        @(negedge clk_dot4x);
        chip_i = chip;
        repeat (2) @(negedge clk_dot4x);
        rst = 1'b0;
    endtask

    task automatic wait_for_rises(input int count);
        while (rise_count < count) begin
            @(posedge clk_dot4x);
        end
    endtask

    task automatic wait_irq_rise(output int at_cycle);
        @(negedge clk_dot4x);
        while (!irq_o) begin
            @(negedge clk_dot4x);
        end
        at_cycle = cycle_count;
    endtask

    // compare on line 100, ack after each rise, two rises one frame apart
    task automatic measure_irq_period(input chip_t chip);
        int t_first;
        int t_next;
        apply_reset(chip);
        @(posedge clk_dot4x);
        ba_must_stay_high = 1'b1;
        reg_write(`VIC_REG_RASTER, 8'd100);
        reg_write(`VIC_REG_CTRL1, 8'h00);
        // compare value 0 already hit line 0
        reg_write(`VIC_REG_IRQ, 8'h01);
        reg_write(`VIC_REG_IRQ_EN, 8'h01);
        check_bit("irq before line 100", 1'b0, irq_o);
        wait_irq_rise(t_first);
        reg_write(`VIC_REG_IRQ, 8'h01);
        check_bit("irq after ack", 1'b0, irq_o);
        wait_irq_rise(t_next);
        check_count($sformatf("irq period, chip %0d", chip), frame_ticks(chip),
                    t_next - t_first);
    endtask

    // --------------------
    // checker
    // --------------------
    always @(negedge clk_dot4x) begin
        int line;
        if (rst) begin
            phi_prev         = 1'b0;
            seen_rise        = 1'b0;
            rise_count       = 0;
            ticks_since_rise = 0;
            high_ticks       = 0;
            ba_hist          = 4'b1111;
            aec_expect       = 1'b0;
            for (int i = 0; i < PAL_LINES; i++) begin
                ba_low_count[i] = 0;
            end
        end else begin
            if (clk_phi_o && !phi_prev) begin
                // full period from one rise to the next
                if (seen_rise) begin
                    check_count("phi period", 2 * `VIC_PHASE_TICKS, ticks_since_rise);
                    check_count("phi high ticks", `VIC_PHASE_TICKS, high_ticks);
                end
                seen_rise        = 1'b1;
                ticks_since_rise = 1;
                high_ticks       = 1;
                ba_hist          = {ba_hist[2:0], ba_o};
                aec_expect       = expected_aec(ba_hist);
                // each rise lands inside one cycle of the line
                line = rise_count / line_cycles(chip_i);
                if (!ba_o && line < PAL_LINES) begin
                    ba_low_count[line] += 1;
                end
                rise_count += 1;
            end else begin
                ticks_since_rise += 1;
                if (clk_phi_o) begin
                    high_ticks += 1;
                end
            end
            if (clk_phi_o) begin
                check_bit("aec in phi high", aec_expect, aec_o);
            end else begin
                check_bit("aec in phi low", 1'b0, aec_o);
            end
            if (irq_must_stay_low) begin
                check_bit("irq with erst clear", 1'b0, irq_o);
            end
            if (ba_must_stay_high) begin
                check_bit("ba with den clear", 1'b1, ba_o);
            end
            phi_prev = clk_phi_o;
        end
    end

    always @(posedge clk_dot4x) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            abort_run();
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        reg_data_t rd_data;
        int        expect_count;
        clk_dot4x         = 1'b0;
        rst               = 1'b1;
        chip_i            = `VIC_CHIP_6569;
        ce_i              = 1'b1;
        rw_i              = 1'b1;
        adi_i             = '0;
        dbi_i             = '0;
        cycle_count       = 0;
        irq_must_stay_low = 1'b0;
        ba_must_stay_high = 1'b0;

        // interrupt control with erst clear
        apply_reset(`VIC_CHIP_6569);
        reg_write(`VIC_REG_RASTER, 8'd10);
        reg_write(`VIC_REG_IRQ, 8'h01);
        @(posedge clk_dot4x);
        irq_must_stay_low = 1'b1;
        reg_read(`VIC_REG_IRQ, rd_data);
        check_data("irq idle", 8'h7e, rd_data);
        reg_read(`VIC_REG_IRQ_EN, rd_data);
        check_data("irq enable after reset", 8'hfe, rd_data);
        wait_for_rises(12 * line_cycles(`VIC_CHIP_6569));
        reg_read(`VIC_REG_IRQ, rd_data);
        check_data("irq latched, erst clear", 8'h7f, rd_data);
        reg_write(`VIC_REG_IRQ, 8'h01);
        reg_read(`VIC_REG_IRQ, rd_data);
        check_data("irq after ack", 8'h7e, rd_data);
        reg_write(`VIC_REG_IRQ_EN, 8'h01);
        reg_read(`VIC_REG_IRQ_EN, rd_data);
        check_data("irq enable readback", 8'hff, rd_data);
        // raster bit 8 reads 0 this early in the frame
        reg_write(`VIC_REG_CTRL1, 8'h15);
        reg_read(`VIC_REG_CTRL1, rd_data);
        check_data("ctrl1 readback", 8'h15, rd_data);

        // badlines over one pal frame, den set and yscroll 3
        apply_reset(`VIC_CHIP_6569);
        reg_write(`VIC_REG_CTRL1, 8'h13);
        wait_for_rises(PAL_LINES * line_cycles(`VIC_CHIP_6569));
        for (int line = 0; line < PAL_LINES; line++) begin
            expect_count = 0;
            if (is_badline(line, 3'd3)) begin
                expect_count = int'(`VIC_BA_CYCLE_LAST) - int'(`VIC_BA_CYCLE_FIRST) + 1;
            end
            check_count($sformatf("ba low samples, line %0d", line), expect_count,
                        ba_low_count[line]);
        end

        // frame length per chip, den clear throughout
        measure_irq_period(`VIC_CHIP_6567R8);
        measure_irq_period(`VIC_CHIP_6567R56A);
        measure_irq_period(`VIC_CHIP_6569);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: all.f
+incdir+logic
+incdir+bench
logic/vic_pkg.sv
logic/phase_gen.sv
logic/raster_counter.sv
logic/vic_registers.sv
logic/badline_arbiter.sv
logic/vic_top.sv
bench/tb_vic.sv

// File: Makefile
SIM  := obj_dir/Vtb_vic
SRCS := $(wildcard logic/*.sv logic/*.svh bench/*.sv bench/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_vic -f all.f

# pass or fail is taken from the log
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
